//--- all.f
design/mgmt_pkg.sv
design/port_pkg.sv
design/spi_slave.sv
design/mgmt_regs.sv
design/port_stats.sv
design/switch_mgmt_top.sv
verification/tb_switch_mgmt.sv

//--- Makefile
SIM      := verilator
SIMFLAGS := --binary --assert -j 0
TOP      := tb_switch_mgmt
FILELIST := all.f
OBJDIR   := obj_dir

BIN     := $(OBJDIR)/V$(TOP)
SOURCES := $(filter-out +%,$(shell cat $(FILELIST)))

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(SIMFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -q "TB PASSED"

clean:
	rm -rf $(OBJDIR)

//--- verification/tb_switch_mgmt.sv
`timescale 1ns/1ns

module tb_switch_mgmt;

    localparam int HALF_SCK    = 10;
    localparam int ACK_TIMEOUT = 50;

    logic                           clk;
    logic                           rst_n;
    logic                           csb;
    logic                           sck;
    logic                           mosi;
    logic                           miso;
    logic [port_pkg::NUM_PORTS-1:0] rx_dv;
    logic [port_pkg::NUM_PORTS-1:0] rx_er;
    logic [31:0]                    rng;
    int                             exp_frames [port_pkg::NUM_PORTS];
    int                             exp_errors [port_pkg::NUM_PORTS];

    switch_mgmt_top switch_mgmt_top_inst (
        .i_clk        (clk),
        .i_rst_n      (rst_n),
        .i_csb        (csb),
        .i_sck        (sck),
        .i_mosi       (mosi),
        .o_miso       (miso),
        .i_gmii_rx_dv (rx_dv),
        .i_gmii_rx_er (rx_er)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic fail_run(input string line);
        $display("%s", line);
        $display("TB FAILED");
        $fatal(1, "simulation stopped on first error");
    endtask

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] next_rand();
        rng = xorshift32(rng);
        return rng;
    endfunction

    function automatic logic [6:0] glb_addr(input logic [5:0] idx);
        return {1'b0, idx};
    endfunction

    function automatic logic [6:0] port_addr(input logic [1:0] port, input logic [3:0] idx);
        return {1'b1, port, idx};
    endfunction

    task automatic check_value(input string what, input logic [15:0] got,
                               input logic [15:0] exp);
        assert (got == exp) else
            fail_run($sformatf("[FAIL] %0t ns: %s read %h, expected %h", $time, what, got, exp));
    endtask

    // ack is a one-cycle pulse, seen at the falling edge
    task automatic wait_ack();
        int n;
        n = 0;
        while (!switch_mgmt_top_inst.spi_ack) begin
            @(negedge clk);
            n++;
            if (n > ACK_TIMEOUT) begin
                fail_run($sformatf("timeout at %0t ns: register block never acked", $time));
            end
        end
    endtask

    // mode 0 frame, miso sampled just before each sck rise
    task automatic spi_transfer(input logic wr, input logic [6:0] addr,
                                input logic [15:0] wdata, output logic [15:0] rdata);
        logic [23:0] frame;
        frame = {wr, addr, wdata};
        rdata = '0;
        csb = 1'b0;
        repeat (HALF_SCK) @(negedge clk);
        for (int i = 23; i >= 0; i--) begin
            mosi = frame[i];
            repeat (HALF_SCK) @(negedge clk);
            if (i < 16) begin
                rdata = {rdata[14:0], miso};
            end
            sck = 1'b1;
            if ((i == 16 && !wr) || (i == 0 && wr)) begin
                wait_ack();
            end
            repeat (HALF_SCK) @(negedge clk);
            sck = 1'b0;
        end
        repeat (HALF_SCK) @(negedge clk);
        csb  = 1'b1;
        mosi = 1'b0;
        repeat (HALF_SCK) @(negedge clk);
    endtask

    task automatic read_reg(input logic [6:0] addr, output logic [15:0] data);
        spi_transfer(1'b0, addr, 16'h0000, data);
    endtask

    task automatic write_reg(input logic [6:0] addr, input logic [15:0] data);
        logic [15:0] unused;
        spi_transfer(1'b1, addr, data, unused);
    endtask

    task automatic read_timestamp(output logic [31:0] ts);
        logic [15:0] lo;
        logic [15:0] hi;
        read_reg(glb_addr(mgmt_pkg::REG_TS_LO), lo);
        read_reg(glb_addr(mgmt_pkg::REG_TS_HI), hi);
        ts = {hi, lo};
    endtask

    // one frame on one port, optional error strobe somewhere inside it
    task automatic send_frame(input int port, input bit with_err);
        int len;
        int gap;
        int err_pos;
        len     = 1 + int'(next_rand() % 20);
        gap     = 1 + int'(next_rand() % 4);
        err_pos = int'(next_rand() % 32'(len));
        for (int i = 0; i < len; i++) begin
            rx_dv[port] = 1'b1;
            rx_er[port] = with_err && (i == err_pos);
            @(negedge clk);
        end
        rx_dv[port] = 1'b0;
        rx_er[port] = 1'b0;
        repeat (gap) @(negedge clk);
    endtask

    // miso may lag csb through the synchronizer
    a_miso_idle: assert property (
        @(posedge clk) disable iff (!rst_n)
        (csb && $past(csb) && $past(csb, 2) && $past(csb, 3)) |-> !miso
    ) else fail_run($sformatf("[FAIL] %0t ns: miso high while csb high", $time));

    initial begin
        logic [15:0] rdata;
        logic [15:0] wval;
        logic [31:0] t1;
        logic [31:0] t2;
        int          n;
        int          p;
        int          k;
        rng   = 32'h090b_7a8f;
        rst_n = 1'b0;
        csb   = 1'b1;
        sck   = 1'b0;
        mosi  = 1'b0;
        rx_dv = '0;
        rx_er = '0;
        repeat (10) @(negedge clk);
        rst_n = 1'b1;
        repeat (5) @(negedge clk);

        assert (miso == 1'b0) else
            fail_run($sformatf("[FAIL] %0t ns: miso not 0 after reset", $time));
        read_reg(glb_addr(mgmt_pkg::REG_ID), rdata);
        check_value("ID", rdata, 16'h5377);

        for (int i = 0; i < 4; i++) begin
            wval = 16'(next_rand() >> 16);
            write_reg(glb_addr(mgmt_pkg::REG_SCRATCH), wval);
            read_reg(glb_addr(mgmt_pkg::REG_SCRATCH), rdata);
            check_value("scratch", rdata, wval);
        end
        write_reg(glb_addr(6'd20), 16'hbeef);
        read_reg(glb_addr(6'd20), rdata);
        check_value("unmapped global", rdata, 16'h0000);

        // distinct count per port, last one wraps the counter
        for (int port = 0; port < port_pkg::NUM_PORTS; port++) begin
            n = port * 7 + 2 + int'(next_rand() % 5);
            if (port == port_pkg::NUM_PORTS - 1) begin
                n = n + 256;
            end
            for (int i = 0; i < n; i++) begin
                send_frame(port, 1'b0);
            end
            exp_frames[port] = exp_frames[port] + n;
        end
        for (int port = 0; port < port_pkg::NUM_PORTS; port++) begin
            read_reg(port_addr(2'(port), port_pkg::PREG_RX_FRAMES), rdata);
            check_value($sformatf("port %0d frames", port), rdata, 16'(exp_frames[port] % 256));
        end

        p = int'(next_rand() % 4);
        k = 2 + int'(next_rand() % 5);
        for (int i = 0; i < k; i++) begin
            send_frame(p, 1'b1);
            send_frame(p, 1'b0);
        end
        exp_frames[p] = exp_frames[p] + 2 * k;
        exp_errors[p] = exp_errors[p] + k;
        for (int port = 0; port < port_pkg::NUM_PORTS; port++) begin
            read_reg(port_addr(2'(port), port_pkg::PREG_RX_ERRORS), rdata);
            check_value($sformatf("port %0d errors", port), rdata, 16'(exp_errors[port] % 256));
        end
        write_reg(port_addr(2'(p), port_pkg::PREG_RX_ERRORS), 16'h0000);
        read_reg(port_addr(2'(p), port_pkg::PREG_RX_ERRORS), rdata);
        check_value("errors after clear", rdata, 16'h0000);
        read_reg(port_addr(2'(p), port_pkg::PREG_RX_FRAMES), rdata);
        check_value("frames after clear", rdata, 16'(exp_frames[p] % 256));

        read_timestamp(t1);
        repeat (100 + int'(next_rand() % 300)) @(negedge clk);
        read_timestamp(t2);
        assert (t2 > t1) else
            fail_run($sformatf("[FAIL] %0t ns: timestamp %h not after %h", $time, t2, t1));
        assert (t1 % 32'd8 == 0 && t2 % 32'd8 == 0) else
            fail_run($sformatf("[FAIL] %0t ns: timestamp %h or %h not a step multiple",
                               $time, t1, t2));

        $display("TB PASSED");
        $finish;
    end

endmodule

//--- design/switch_mgmt_top.sv
`timescale 1ns/1ns

module switch_mgmt_top (
    input  logic                           i_clk,
    input  logic                           i_rst_n,
    input  logic                           i_csb,
    input  logic                           i_sck,
    input  logic                           i_mosi,
    output logic                           o_miso,
    input  logic [port_pkg::NUM_PORTS-1:0] i_gmii_rx_dv,
    input  logic [port_pkg::NUM_PORTS-1:0] i_gmii_rx_er
);

    logic                                          spi_req;
    logic                                          spi_ack;
    mgmt_pkg::spi_cmd_t                            spi_cmd;
    logic [mgmt_pkg::SPI_DATA_W-1:0]               spi_rdata;
    logic [port_pkg::NUM_PORTS-1:0]                port_sel;
    port_pkg::port_req_t                           port_req;
    port_pkg::port_resp_t [port_pkg::NUM_PORTS-1:0] port_resp;

    spi_slave spi_slave_inst (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .i_csb   (i_csb),
        .i_sck   (i_sck),
        .i_mosi  (i_mosi),
        .o_miso  (o_miso),
        .o_req   (spi_req),
        .o_cmd   (spi_cmd),
        .i_ack   (spi_ack),
        .i_rdata (spi_rdata)
    );

    mgmt_regs mgmt_regs_inst (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .i_req       (spi_req),
        .i_cmd       (spi_cmd),
        .o_ack       (spi_ack),
        .o_rdata     (spi_rdata),
        .o_port_sel  (port_sel),
        .o_port_req  (port_req),
        .i_port_resp (port_resp)
    );

    // one statistics block per port
    for (genvar g = 0; g < port_pkg::NUM_PORTS; g++) begin : g_port
        port_stats port_stats_inst (
            .i_clk   (i_clk),
            .i_rst_n (i_rst_n),
            .i_rx_dv (i_gmii_rx_dv[g]),
            .i_rx_er (i_gmii_rx_er[g]),
            .i_sel   (port_sel[g]),
            .i_req   (port_req),
            .o_resp  (port_resp[g])
        );
    end

endmodule

//--- design/port_stats.sv
`timescale 1ns/1ns

module port_stats (
    input  logic                 i_clk,
    input  logic                 i_rst_n,
    input  logic                 i_rx_dv,
    input  logic                 i_rx_er,
    input  logic                 i_sel,
    input  port_pkg::port_req_t  i_req,
    output port_pkg::port_resp_t o_resp
);

    logic                       dv_q;
    logic                       err_seen;
    logic                       frame_end;
    logic                       clr_frames;
    logic                       clr_errors;
    logic [port_pkg::CNT_W-1:0] rx_frames;
    logic [port_pkg::CNT_W-1:0] rx_errors;
    logic                       resp_valid;
    logic [port_pkg::CNT_W-1:0] resp_data;

    // falling edge of dv closes a frame
    assign frame_end  = dv_q && !i_rx_dv;
    assign clr_frames = i_sel && i_req.wr && i_req.idx == port_pkg::PREG_RX_FRAMES;
    assign clr_errors = i_sel && i_req.wr && i_req.idx == port_pkg::PREG_RX_ERRORS;

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            dv_q      <= 1'b0;
            err_seen  <= 1'b0;
            rx_frames <= '0;
            rx_errors <= '0;
        end else begin
            dv_q <= i_rx_dv;
            if (frame_end) begin
                err_seen <= 1'b0;
            end else if (i_rx_dv && i_rx_er) begin
                err_seen <= 1'b1;
            end
            // clear wins over a frame ending in the same cycle
            if (clr_frames) begin
                rx_frames <= '0;
            end else if (frame_end) begin
                rx_frames <= rx_frames + 1'b1;
            end
            if (clr_errors) begin
                rx_errors <= '0;
            end else if (frame_end && err_seen) begin
                rx_errors <= rx_errors + 1'b1;
            end
        end
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            resp_valid <= 1'b0;
        end else begin
            resp_valid <= i_sel;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_sel) begin
            case (i_req.idx)
                port_pkg::PREG_RX_FRAMES: resp_data <= rx_frames;
                port_pkg::PREG_RX_ERRORS: resp_data <= rx_errors;
                default:                  resp_data <= '0;
            endcase
        end
    end

    assign o_resp = '{valid: resp_valid, data: resp_data};

    a_resp_timing: assert property (
        @(posedge i_clk) disable iff (!i_rst_n)
        o_resp.valid == $past(i_sel)
    );

endmodule

//--- design/mgmt_regs.sv
`timescale 1ns/1ns

module mgmt_regs (
    input  logic                                         i_clk,
    input  logic                                         i_rst_n,
    input  logic                                         i_req,
    input  mgmt_pkg::spi_cmd_t                           i_cmd,
    output logic                                         o_ack,
    output logic [mgmt_pkg::SPI_DATA_W-1:0]              o_rdata,
    output logic [port_pkg::NUM_PORTS-1:0]               o_port_sel,
    output port_pkg::port_req_t                          o_port_req,
    input  port_pkg::port_resp_t [port_pkg::NUM_PORTS-1:0] i_port_resp
);

    mgmt_pkg::reg_addr_u             addr;
    logic                            glb_req;
    logic                            port_req;
    logic [mgmt_pkg::SPI_DATA_W-1:0] glb_rdata;
    logic [mgmt_pkg::SPI_DATA_W-1:0] scratch;
    logic [mgmt_pkg::SPI_DATA_W-1:0] ts_hi;
    logic [mgmt_pkg::TS_W-1:0]       ts;
    logic [port_pkg::NUM_PORTS-1:0]  resp_valid;
    port_pkg::port_resp_t            resp;

    assign addr     = i_cmd.addr;
    assign glb_req  = i_req && !addr.glb.is_port;
    assign port_req = i_req && addr.prt.is_port;

    // free-running ns counter
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            ts <= '0;
        end else begin
            ts <= ts + mgmt_pkg::NS_PER_CLK;
        end
    end

    // reading the low half freezes the high half for the next read
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            scratch <= '0;
            ts_hi   <= '0;
        end else if (glb_req) begin
            if (i_cmd.wr && addr.glb.index == mgmt_pkg::REG_SCRATCH) begin
                scratch <= i_cmd.wdata;
            end
            if (!i_cmd.wr && addr.glb.index == mgmt_pkg::REG_TS_LO) begin
                ts_hi <= ts[mgmt_pkg::TS_W-1:mgmt_pkg::SPI_DATA_W];
            end
        end
    end

    always_comb begin
        case (addr.glb.index)
            mgmt_pkg::REG_ID:      glb_rdata = mgmt_pkg::ID_VALUE;
            mgmt_pkg::REG_SCRATCH: glb_rdata = scratch;
            mgmt_pkg::REG_TS_LO:   glb_rdata = ts[mgmt_pkg::SPI_DATA_W-1:0];
            mgmt_pkg::REG_TS_HI:   glb_rdata = ts_hi;
            default:               glb_rdata = '0;
        endcase
    end

    // one-hot port select, index shared by all ports
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_port_sel <= '0;
        end else begin
            o_port_sel <= '0;
            if (port_req) begin
                o_port_sel[addr.prt.port] <= 1'b1;
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (port_req) begin
            o_port_req.wr  <= i_cmd.wr;
            o_port_req.idx <= addr.prt.index;
        end
    end

    // port 0 has priority
    always_comb begin
        resp = '0;
        for (int i = port_pkg::NUM_PORTS - 1; i >= 0; i--) begin
            resp_valid[i] = i_port_resp[i].valid;
            if (i_port_resp[i].valid) begin
                resp = i_port_resp[i];
            end
        end
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_ack <= 1'b0;
        end else begin
            o_ack <= glb_req || resp.valid;
        end
    end

    always_ff @(posedge i_clk) begin
        if (glb_req) begin
            o_rdata <= glb_rdata;
        end else if (resp.valid) begin
            o_rdata <= {{(mgmt_pkg::SPI_DATA_W - port_pkg::CNT_W){1'b0}}, resp.data};
        end
    end

    a_sel_onehot: assert property (
        @(posedge i_clk) disable iff (!i_rst_n)
        $onehot0(o_port_sel)
    );

    // only the selected port may answer
    a_resp_single: assert property (
        @(posedge i_clk) disable iff (!i_rst_n)
        $onehot0(resp_valid)
    );

endmodule

//--- design/spi_slave.sv
`timescale 1ns/1ns

module spi_slave (
    input  logic                            i_clk,
    input  logic                            i_rst_n,
    input  logic                            i_csb,
    input  logic                            i_sck,
    input  logic                            i_mosi,
    output logic                            o_miso,
    output logic                            o_req,
    output mgmt_pkg::spi_cmd_t              o_cmd,
    input  logic                            i_ack,
    input  logic [mgmt_pkg::SPI_DATA_W-1:0] i_rdata
);

    logic [1:0]                      csb_sync;
    logic [2:0]                      sck_sync;
    logic [1:0]                      mosi_sync;
    logic                            frame_on;
    logic                            sck_rise;
    logic                            sck_fall;
    logic [mgmt_pkg::BIT_CNT_W-1:0]  bit_cnt;
    logic [mgmt_pkg::CMD_W-1:0]      shift_q;
    logic [mgmt_pkg::CMD_W-1:0]      shift_d;
    logic                            rd_hit;
    logic                            wr_hit;
    logic [mgmt_pkg::SPI_DATA_W-1:0] rd_shift;

    // two flops per input, third sck stage for edge detect
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            csb_sync  <= '1;
            sck_sync  <= '0;
            mosi_sync <= '0;
        end else begin
            csb_sync  <= {csb_sync[0], i_csb};
            sck_sync  <= {sck_sync[1:0], i_sck};
            mosi_sync <= {mosi_sync[0], i_mosi};
        end
    end

    assign frame_on = !csb_sync[1];
    assign sck_rise = sck_sync[1] && !sck_sync[2];
    assign sck_fall = !sck_sync[1] && sck_sync[2];
    assign shift_d  = {shift_q[mgmt_pkg::CMD_W-2:0], mosi_sync[1]};

    // read goes out once the address is in, write once the data is in
    assign rd_hit = frame_on && sck_rise && (bit_cnt == mgmt_pkg::RD_REQ_CNT)
                    && !shift_d[mgmt_pkg::SPI_ADDR_W];
    assign wr_hit = frame_on && sck_rise && (bit_cnt == mgmt_pkg::WR_REQ_CNT)
                    && shift_d[mgmt_pkg::CMD_W-1];

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            bit_cnt <= '0;
            o_req   <= 1'b0;
        end else begin
            o_req <= rd_hit || wr_hit;
            if (!frame_on) begin
                bit_cnt <= '0;
            end else if (sck_rise) begin
                bit_cnt <= bit_cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (frame_on && sck_rise) begin
            shift_q <= shift_d;
        end
        if (rd_hit) begin
            o_cmd <= '{wr: 1'b0, addr: shift_d[mgmt_pkg::SPI_ADDR_W-1:0], wdata: '0};
        end else if (wr_hit) begin
            o_cmd <= shift_d;
        end
    end

    // read data lands before the fall after bit 8, then one bit per fall
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            rd_shift <= '0;
            o_miso   <= 1'b0;
        end else if (!frame_on) begin
            rd_shift <= '0;
            o_miso   <= 1'b0;
        end else if (i_ack && !o_cmd.wr) begin
            rd_shift <= i_rdata;
        end else if (sck_fall) begin
            o_miso   <= rd_shift[mgmt_pkg::SPI_DATA_W-1];
            rd_shift <= {rd_shift[mgmt_pkg::SPI_DATA_W-2:0], 1'b0};
        end
    end

    // a request must land inside the frame that carried it
    a_no_req_idle: assert property (
        @(posedge i_clk) disable iff (!i_rst_n)
        i_csb |-> !o_req
    );

endmodule

//--- design/port_pkg.sv
package port_pkg;

    localparam int NUM_PORTS  = 4;
    localparam int PORT_REG_W = 4;
    localparam int CNT_W      = 8;

    // one request bus shared by all ports, qualified by a per-port select
    typedef struct packed {
        logic                  wr;
        logic [PORT_REG_W-1:0] idx;
    } port_req_t;

    typedef struct packed {
        logic             valid;
        logic [CNT_W-1:0] data;
    } port_resp_t;

    // port register map
    localparam logic [PORT_REG_W-1:0] PREG_RX_FRAMES = 4'd0;
    localparam logic [PORT_REG_W-1:0] PREG_RX_ERRORS = 4'd1;

endpackage

//--- design/mgmt_pkg.sv
package mgmt_pkg;

    // register access word carried by one SPI frame
    localparam int SPI_ADDR_W = 7;
    localparam int SPI_DATA_W = 16;
    localparam int CMD_W      = 1 + SPI_ADDR_W + SPI_DATA_W;
    localparam int BIT_CNT_W  = $clog2(CMD_W + 1);

    // bit counter values at the last address bit and the last data bit
    localparam logic [BIT_CNT_W-1:0] RD_REQ_CNT = BIT_CNT_W'(SPI_ADDR_W);
    localparam logic [BIT_CNT_W-1:0] WR_REQ_CNT = BIT_CNT_W'(CMD_W - 1);

    // sent msb first, write flag leads
    typedef struct packed {
        logic                  wr;
        logic [SPI_ADDR_W-1:0] addr;
        logic [SPI_DATA_W-1:0] wdata;
    } spi_cmd_t;

    // address layout
    localparam int GLB_IDX_W  = SPI_ADDR_W - 1;
    localparam int PORT_ID_W  = 2;
    localparam int PORT_IDX_W = SPI_ADDR_W - 1 - PORT_ID_W;

    typedef struct packed {
        logic                 is_port;
        logic [GLB_IDX_W-1:0] index;
    } glb_addr_t;

    typedef struct packed {
        logic                  is_port;
        logic [PORT_ID_W-1:0]  port;
        logic [PORT_IDX_W-1:0] index;
    } port_addr_t;

    typedef union packed {
        glb_addr_t  glb;
        port_addr_t prt;
    } reg_addr_u;

    // global register map
    localparam logic [GLB_IDX_W-1:0] REG_ID      = 6'd0;
    localparam logic [GLB_IDX_W-1:0] REG_SCRATCH = 6'd1;
    localparam logic [GLB_IDX_W-1:0] REG_TS_LO   = 6'd2;
    localparam logic [GLB_IDX_W-1:0] REG_TS_HI   = 6'd3;

    localparam logic [SPI_DATA_W-1:0] ID_VALUE = 16'h5377;

    // timestamp in ns, 125 MHz system clock
    localparam int              TS_W       = 32;
    localparam logic [TS_W-1:0] NS_PER_CLK = 32'd8;

endpackage
